// File: hdl/stm_pkg.sv
package stm_pkg;

  localparam int NUM_TRANS = 8;
  localparam int DEPTH = 16;
  localparam int NUM_SEGMENT = 2;
  localparam int IDX_W = 4;
  localparam int TRANS_W = 3;
  localparam int MEM_WORDS = NUM_SEGMENT * DEPTH * NUM_TRANS;
  localparam logic [15:0] REP_INFINITE = 16'hffff;

  localparam int AXI_ADDR_W = 12;
  localparam int AXI_DATA_W = 32;

  localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL = 12'h000;
  localparam logic [AXI_ADDR_W-1:0] ADDR_TRANS = 12'h004;
  localparam logic [AXI_ADDR_W-1:0] ADDR_CYCLE0 = 12'h008;
  localparam logic [AXI_ADDR_W-1:0] ADDR_CYCLE1 = 12'h00c;
  localparam logic [AXI_ADDR_W-1:0] ADDR_FREQ_DIV0 = 12'h010;
  localparam logic [AXI_ADDR_W-1:0] ADDR_FREQ_DIV1 = 12'h014;
  localparam logic [AXI_ADDR_W-1:0] ADDR_REP0 = 12'h018;
  localparam logic [AXI_ADDR_W-1:0] ADDR_REP1 = 12'h01c;
  localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS = 12'h020;
  localparam logic [AXI_ADDR_W-1:0] MEM_BASE = 12'h400;

  typedef enum logic [1:0] {
    TRANS_IMMEDIATE = 2'd0,
    TRANS_SYNC_IDX  = 2'd1,
    TRANS_GPIO      = 2'd2
  } trans_mode_e;

  typedef logic [NUM_SEGMENT-1:0][15:0] seg_word_t;
  typedef logic [NUM_SEGMENT-1:0][IDX_W-1:0] seg_idx_t;

  typedef struct packed {
    logic update;
    logic req_rd_segment;
    trans_mode_e transition_mode;
    logic [7:0] transition_value;
    seg_word_t cycle;
    seg_word_t freq_div;
    seg_word_t rep;
  } stm_settings_t;

  typedef struct packed {
    logic en;
    logic seg;
    logic [IDX_W-1:0] idx;
    logic [TRANS_W-1:0] trans;
    logic [7:0] intensity;
    logic [7:0] phase;
  } pattern_wr_t;

  typedef struct packed {
    logic segment;
    logic stop;
    logic [IDX_W-1:0] idx;
  } stm_status_t;

endpackage

// File: hdl/stm_regs.sv
`timescale 1ns/1ps
module stm_regs
  import stm_pkg::*;
(
  input  logic                  CLK,
  input  logic                  reset,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  output stm_settings_t         settings,
  output pattern_wr_t           pattern_wr,
  input  stm_status_t           status
);

  logic wr_go;
  logic wr_en;
  logic ar_go;
  logic mem_sel;
  logic [AXI_DATA_W-1:0] rd_mux;

  assign wr_go = awvalid && wvalid && !awready && !bvalid; // both channels held, none in flight.
  assign wr_en = awready && awvalid && wvalid;
  assign ar_go = arvalid && !arready && !rvalid;
  assign mem_sel = awaddr[AXI_ADDR_W-1:10] == MEM_BASE[AXI_ADDR_W-1:10];

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  always_ff @(posedge CLK) begin
    if (reset) begin
      awready <= 1'b0;
      wready <= 1'b0;
      bvalid <= 1'b0;
      arready <= 1'b0;
      rvalid <= 1'b0;
      settings <= '0;
      pattern_wr.en <= 1'b0;
    end else begin
      awready <= wr_go;
      wready <= wr_go;
      if (wr_en) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end

      settings.update <= wr_en && (awaddr == ADDR_CTRL) && wdata[0];
      if (wr_en) begin
        case (awaddr)
          ADDR_TRANS: begin
            settings.req_rd_segment <= wdata[0];
            settings.transition_mode <= trans_mode_e'(wdata[2:1]);
            settings.transition_value <= wdata[15:8];
          end
          ADDR_CYCLE0:    settings.cycle[0] <= wdata[15:0];
          ADDR_CYCLE1:    settings.cycle[1] <= wdata[15:0];
          ADDR_FREQ_DIV0: settings.freq_div[0] <= wdata[15:0];
          ADDR_FREQ_DIV1: settings.freq_div[1] <= wdata[15:0];
          ADDR_REP0:      settings.rep[0] <= wdata[15:0];
          ADDR_REP1:      settings.rep[1] <= wdata[15:0];
          default: ;
        endcase
      end

      // word offset is {seg, idx, trans}.
      pattern_wr.en <= wr_en && mem_sel;
      pattern_wr.seg <= awaddr[9];
      pattern_wr.idx <= awaddr[8:5];
      pattern_wr.trans <= awaddr[4:2];
      pattern_wr.intensity <= wdata[15:8];
      pattern_wr.phase <= wdata[7:0];

      arready <= ar_go;
      if (arready) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    case (araddr)
      ADDR_TRANS: rd_mux = {16'd0, settings.transition_value, 5'd0,
                            settings.transition_mode, settings.req_rd_segment};
      ADDR_CYCLE0:    rd_mux[15:0] = settings.cycle[0];
      ADDR_CYCLE1:    rd_mux[15:0] = settings.cycle[1];
      ADDR_FREQ_DIV0: rd_mux[15:0] = settings.freq_div[0];
      ADDR_FREQ_DIV1: rd_mux[15:0] = settings.freq_div[1];
      ADDR_REP0:      rd_mux[15:0] = settings.rep[0];
      ADDR_REP1:      rd_mux[15:0] = settings.rep[1];
      ADDR_STATUS:    rd_mux = {20'd0, status.idx, 6'd0, status.stop, status.segment};
      default: ; // control and pattern memory read as zero.
    endcase
  end

  always_ff @(posedge CLK) begin
    if (arready) begin
      rdata <= rd_mux;
    end
  end

  a_bvalid_hold: assert property (@(posedge CLK) disable iff (reset)
    bvalid && !bready |=> bvalid);

endmodule

// File: hdl/stm_timer.sv
`timescale 1ns/1ps
module stm_timer
  import stm_pkg::*;
(
  input  logic      CLK,
  input  logic      reset,
  input  logic      update_settings_in,
  input  seg_word_t cycle,
  input  seg_word_t freq_div,
  output seg_idx_t  idx,
  output logic      update_settings_out
);

  seg_word_t presc;

  always_ff @(posedge CLK) begin
    if (reset) begin
      presc <= '0;
      idx <= '0;
      update_settings_out <= 1'b0;
    end else begin
      update_settings_out <= update_settings_in; // lines up with the restarted counters.
      for (int s = 0; s < NUM_SEGMENT; s++) begin
        if (update_settings_in) begin
          // both segments restart together so they stay phase aligned.
          presc[s] <= '0;
          idx[s] <= '0;
        end else if (presc[s] == freq_div[s] - 16'd1) begin
          presc[s] <= '0;
          if (16'(idx[s]) == cycle[s] - 16'd1) begin
            idx[s] <= '0;
          end else begin
            idx[s] <= idx[s] + 1'b1;
          end
        end else begin
          presc[s] <= presc[s] + 16'd1;
        end
      end
    end
  end

endmodule

// File: hdl/stm_swapchain.sv
`timescale 1ns/1ps
module stm_swapchain
  import stm_pkg::*;
(
  input  logic        CLK,
  input  logic        reset,
  input  logic        update_settings,
  input  logic        req_rd_segment,
  input  trans_mode_e transition_mode,
  input  logic [7:0]  transition_value,
  input  seg_word_t   cycle,
  input  seg_word_t   rep,
  input  seg_idx_t    sync_idx,
  input  logic [3:0]  gpio_in,
  output logic        stop,
  output logic        segment,
  output seg_idx_t    idx
);

  logic [3:0] gpio_meta;
  logic [3:0] gpio_sync;
  logic [3:0] gpio_prev;
  logic gpio_rise;
  logic pending;
  logic req_seg;
  trans_mode_e mode_q;
  logic counting;
  logic [15:0] loop_cnt;
  seg_idx_t idx_q;
  logic [NUM_SEGMENT-1:0] wrap;
  logic switch_now;
  logic last_loop;

  // a wrap is the step from cycle-1 to 0, the restart on update does not count.
  always_comb begin
    for (int s = 0; s < NUM_SEGMENT; s++) begin
      wrap[s] = !update_settings && (sync_idx[s] != idx_q[s]) &&
                (16'(idx_q[s]) == cycle[s] - 16'd1);
    end
  end

  assign gpio_rise = (transition_value < 8'd4) && gpio_sync[transition_value[1:0]] &&
                     !gpio_prev[transition_value[1:0]];

  assign switch_now = pending && (((mode_q == TRANS_SYNC_IDX) && wrap[req_seg]) ||
                                  ((mode_q == TRANS_GPIO) && gpio_rise));

  assign last_loop = counting && !stop && wrap[segment] && (loop_cnt == rep[segment]) &&
                     (rep[segment] != REP_INFINITE);

  always_ff @(posedge CLK) begin
    if (reset) begin
      gpio_meta <= '0;
      gpio_sync <= '0;
      gpio_prev <= '0;
      pending <= 1'b0;
      req_seg <= 1'b0;
      mode_q <= TRANS_IMMEDIATE;
      counting <= 1'b0;
      loop_cnt <= '0;
      idx_q <= '0;
      stop <= 1'b0;
      segment <= 1'b0;
    end else begin
      gpio_meta <= gpio_in;
      gpio_sync <= gpio_meta;
      gpio_prev <= gpio_sync;
      idx_q <= sync_idx;
      if (update_settings && (transition_mode == TRANS_IMMEDIATE)) begin
        segment <= req_rd_segment;
        pending <= 1'b0;
        counting <= 1'b1;
        loop_cnt <= '0;
        stop <= 1'b0;
      end else if (update_settings) begin
        pending <= 1'b1; // held until the sync index or gpio edge arrives.
        req_seg <= req_rd_segment;
        mode_q <= transition_mode;
      end else if (switch_now) begin
        segment <= req_seg;
        pending <= 1'b0;
        counting <= 1'b1;
        loop_cnt <= '0;
        stop <= 1'b0;
      end else if (counting && !stop && wrap[segment]) begin
        loop_cnt <= loop_cnt + 16'd1;
        stop <= last_loop;
      end
    end
  end

  always_comb begin
    for (int s = 0; s < NUM_SEGMENT; s++) begin
      idx[s] = sync_idx[s];
      if ((segment == 1'(s)) && (stop || last_loop)) begin
        idx[s] = cycle[s][IDX_W-1:0] - 1'b1; // parked on the last pattern.
      end
    end
  end

  a_seg_after_req: assert property (@(posedge CLK) disable iff (reset)
    $changed(segment) |-> $past(pending || update_settings));

endmodule

// File: hdl/stm_gain.sv
`timescale 1ns/1ps
module stm_gain
  import stm_pkg::*;
(
  input  logic             CLK,
  input  logic             reset,
  input  logic             start,
  input  logic             segment,
  input  logic [IDX_W-1:0] idx,
  input  pattern_wr_t      pattern_wr,
  output logic [7:0]       intensity,
  output logic [7:0]       phase,
  output logic             dout_valid
);

  logic [15:0] mem [MEM_WORDS];
  logic [15:0] rd_data;
  logic [TRANS_W-1:0] trans_cnt;
  logic active;
  logic seg_q;
  logic [IDX_W-1:0] idx_q;

  always_ff @(posedge CLK) begin
    if (pattern_wr.en) begin
      mem[{pattern_wr.seg, pattern_wr.idx, pattern_wr.trans}] <=
        {pattern_wr.intensity, pattern_wr.phase};
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      active <= 1'b0;
      trans_cnt <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= active; // matches the one cycle read latency.
      if (start) begin
        active <= 1'b1;
        trans_cnt <= '0;
      end else if (active) begin
        trans_cnt <= trans_cnt + 1'b1;
        if (trans_cnt == TRANS_W'(NUM_TRANS - 1)) begin
          active <= 1'b0;
        end
      end
    end
  end

  // the pattern is frozen at start so a later capture cannot tear a burst.
  always_ff @(posedge CLK) begin
    if (start) begin
      seg_q <= segment;
      idx_q <= idx;
    end
    rd_data <= mem[{seg_q, idx_q, trans_cnt}];
  end

  assign intensity = rd_data[15:8];
  assign phase = rd_data[7:0];

endmodule

// File: hdl/stm.sv
`timescale 1ns/1ps
module stm
  import stm_pkg::*;
(
  input  logic          CLK,
  input  logic          reset,
  input  logic          update,
  input  logic [3:0]    gpio_in,
  input  stm_settings_t settings,
  input  pattern_wr_t   pattern_wr,
  output stm_status_t   status,
  output logic [7:0]    intensity,
  output logic [7:0]    phase,
  output logic          dout_valid
);

  seg_idx_t timer_idx;
  seg_idx_t sw_idx;
  logic update_settings;
  logic sw_stop;
  logic sw_segment;
  logic stop_q;
  logic start;
  logic segment;
  logic [IDX_W-1:0] idx;

  stm_timer stm_timer_i (
    .CLK                 (CLK),
    .reset               (reset),
    .update_settings_in  (settings.update),
    .cycle               (settings.cycle),
    .freq_div            (settings.freq_div),
    .idx                 (timer_idx),
    .update_settings_out (update_settings)
  );

  stm_swapchain stm_swapchain_i (
    .CLK              (CLK),
    .reset            (reset),
    .update_settings  (update_settings),
    .req_rd_segment   (settings.req_rd_segment),
    .transition_mode  (settings.transition_mode),
    .transition_value (settings.transition_value),
    .cycle            (settings.cycle),
    .rep              (settings.rep),
    .sync_idx         (timer_idx),
    .gpio_in          (gpio_in),
    .stop             (sw_stop),
    .segment          (sw_segment),
    .idx              (sw_idx)
  );

  stm_gain stm_gain_i (
    .CLK        (CLK),
    .reset      (reset),
    .start      (start),
    .segment    (segment),
    .idx        (idx),
    .pattern_wr (pattern_wr),
    .intensity  (intensity),
    .phase      (phase),
    .dout_valid (dout_valid)
  );

  always_ff @(posedge CLK) begin
    if (reset) begin
      start <= 1'b0;
      segment <= 1'b0;
      idx <= '0;
      stop_q <= 1'b0;
    end else begin
      start <= update;
      stop_q <= sw_stop;
      // the rising stop captures the parked index once. later updates replay it.
      if ((update && !sw_stop) || (sw_stop && !stop_q)) begin
        segment <= sw_segment;
        idx <= sw_idx[sw_segment];
      end
    end
  end

  assign status = '{segment: segment, stop: sw_stop, idx: idx};

  a_start_stream: assert property (@(posedge CLK) disable iff (reset)
    start |-> $past(update) ##2 dout_valid);

endmodule

// File: hdl/stm_top.sv
`timescale 1ns/1ps
module stm_top
  import stm_pkg::*;
(
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  update,
  input  logic [3:0]            gpio_in,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [7:0]            intensity,
  output logic [7:0]            phase,
  output logic                  dout_valid
);

  stm_settings_t settings;
  pattern_wr_t pattern_wr;
  stm_status_t status;

  stm_regs stm_regs_i (
    .CLK        (CLK),
    .reset      (reset),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .settings   (settings),
    .pattern_wr (pattern_wr),
    .status     (status)
  );

  stm stm_i (
    .CLK        (CLK),
    .reset      (reset),
    .update     (update),
    .gpio_in    (gpio_in),
    .settings   (settings),
    .pattern_wr (pattern_wr),
    .status     (status),
    .intensity  (intensity),
    .phase      (phase),
    .dout_valid (dout_valid)
  );

endmodule

// File: tb/stm_tb.sv
`timescale 1ns/1ps
module stm_tb
  import stm_pkg::*;
();

  localparam logic [31:0] SEED = 32'h2a7b_62f7;
  localparam int ROUNDS = 3;
  localparam int ROUND_UPDATES = 8;
  localparam int SWITCH_UPDATES = 9;
  localparam int STOP_UPDATES = 6;
  localparam int NUM_UPDATES = ROUNDS * ROUND_UPDATES + SWITCH_UPDATES + STOP_UPDATES;
  localparam int TIMEOUT_CYCLES = NUM_UPDATES * 200 + 4000;

  logic CLK;
  logic reset;
  logic update;
  logic [3:0] gpio_in;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [AXI_DATA_W-1:0] wdata;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [AXI_ADDR_W-1:0] araddr;
  logic arvalid;
  logic arready;
  logic [AXI_DATA_W-1:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  logic [7:0] intensity;
  logic [7:0] phase;
  logic dout_valid;

  seg_word_t cyc_q; // cycle values the checks compare against.
  logic exp_seg;
  logic park_check;
  logic [IDX_W-1:0] park_idx;
  logic [IDX_W-1:0] burst_idx;
  logic [TRANS_W-1:0] prev_trans;

  stm_top stm_top_i (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic expect_equal(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected)
    else abort_run($sformatf("error %s expected 0x%0h actual 0x%0h", test, expected, actual));
  endtask

  task automatic write_reg(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge CLK);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    do @(negedge CLK); while (!awready);
    @(negedge CLK); // the handshake lands on the edge in between.
    awvalid = 1'b0;
    wvalid = 1'b0;
    while (!bvalid) @(negedge CLK);
    expect_equal("write_bresp", 32'd0, {30'd0, bresp});
    bready = 1'b1;
    @(negedge CLK);
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data);
    @(negedge CLK);
    araddr = addr;
    arvalid = 1'b1;
    do @(negedge CLK); while (!arready);
    @(negedge CLK);
    arvalid = 1'b0;
    while (!rvalid) @(negedge CLK);
    expect_equal("read_rresp", 32'd0, {30'd0, rresp});
    data = rdata;
    rready = 1'b1;
    @(negedge CLK);
    rready = 1'b0;
  endtask

  // one strobe, then idle long enough for the burst to drain.
  task automatic pulse_update(input int gap);
    @(negedge CLK);
    update = 1'b1;
    @(negedge CLK);
    update = 1'b0;
    repeat (gap) @(negedge CLK);
  endtask

  task automatic configure(input logic req, input trans_mode_e mode, input logic [7:0] value,
                           input seg_word_t cyc, input seg_word_t fd, input seg_word_t rep);
    write_reg(ADDR_CYCLE0, {16'd0, cyc[0]});
    write_reg(ADDR_CYCLE1, {16'd0, cyc[1]});
    write_reg(ADDR_FREQ_DIV0, {16'd0, fd[0]});
    write_reg(ADDR_FREQ_DIV1, {16'd0, fd[1]});
    write_reg(ADDR_REP0, {16'd0, rep[0]});
    write_reg(ADDR_REP1, {16'd0, rep[1]});
    cyc_q = cyc;
    write_reg(ADDR_TRANS, {16'd0, value, 5'd0, mode, req});
    write_reg(ADDR_CTRL, 32'd1);
    repeat (4) @(negedge CLK); // update travels through the timer into the swapchain.
  endtask

  task automatic fill_memory();
    logic [7:0] level;
    for (int s = 0; s < NUM_SEGMENT; s++) begin
      for (int i = 0; i < DEPTH; i++) begin
        for (int t = 0; t < NUM_TRANS; t++) begin
          level = 8'(s * 128 + i * 8 + t);
          write_reg(MEM_BASE + 12'(((s * DEPTH + i) * NUM_TRANS + t) * 4),
                    {16'd0, level, ~level});
        end
      end
    end
  endtask

  task automatic check_readback();
    logic [31:0] rd;
    logic [31:0] value;
    logic [AXI_ADDR_W-1:0] regs [6];
    regs = '{ADDR_CYCLE0, ADDR_CYCLE1, ADDR_FREQ_DIV0, ADDR_FREQ_DIV1, ADDR_REP0, ADDR_REP1};
    value = {16'd0, 8'($urandom), 5'd0, 2'($urandom % 3), 1'($urandom)};
    write_reg(ADDR_TRANS, value);
    read_reg(ADDR_TRANS, rd);
    expect_equal("readback_trans", value, rd);
    for (int k = 0; k < 6; k++) begin
      value = {16'd0, 16'($urandom)};
      write_reg(regs[k], value);
      read_reg(regs[k], rd);
      expect_equal($sformatf("readback_%03h", regs[k]), value, rd);
    end
    read_reg(MEM_BASE, rd);
    expect_equal("readback_mem", 32'd0, rd);
  endtask

  task automatic run_round(input logic req);
    seg_word_t cyc;
    seg_word_t fd;
    int period;
    logic [DEPTH-1:0] seen;
    for (int s = 0; s < NUM_SEGMENT; s++) begin
      cyc[s] = 16'(4 + $urandom % 13);
      fd[s] = 16'(1 + $urandom % 4);
    end
    configure(req, TRANS_IMMEDIATE, 8'd0, cyc, fd, {REP_INFINITE, REP_INFINITE});
    exp_seg = req;
    period = int'(cyc[req]) * int'(fd[req]);
    seen = '0;
    for (int u = 0; u < ROUND_UPDATES; u++) begin
      pulse_update(12 + period + int'($urandom % period));
      seen[burst_idx] = 1'b1;
    end
    assert ($countones(seen) > 1)
    else abort_run($sformatf("index_range saw a single pattern index over %0d updates",
                             ROUND_UPDATES));
  endtask

  task automatic check_transitions();
    seg_word_t cyc;
    seg_word_t fd;
    logic [1:0] bit_sel;
    cyc = {16'd8, 16'd8};
    fd = {16'd2, 16'd2};
    bit_sel = 2'($urandom);
    configure(1'b1, TRANS_IMMEDIATE, 8'd0, cyc, fd, {REP_INFINITE, REP_INFINITE});
    exp_seg = 1'b1;
    repeat (3) pulse_update(12 + int'($urandom % 40));
    configure(1'b0, TRANS_GPIO, {6'd0, bit_sel}, cyc, fd, {REP_INFINITE, REP_INFINITE});
    repeat (2) pulse_update(12 + int'($urandom % 40));
    @(negedge CLK);
    gpio_in[bit_sel + 2'd1] = 1'b1; // a neighbouring bit must not trigger the swap.
    pulse_update(20);
    @(negedge CLK);
    gpio_in[bit_sel] = 1'b1;
    repeat (5) @(negedge CLK);
    exp_seg = 1'b0;
    repeat (3) pulse_update(12 + int'($urandom % 40));
    gpio_in = '0;
  endtask

  task automatic check_stop();
    seg_word_t cyc;
    seg_word_t fd;
    logic [31:0] rd;
    logic [31:0] expected;
    int period;
    for (int s = 0; s < NUM_SEGMENT; s++) begin
      cyc[s] = 16'(4 + $urandom % 13);
      fd[s] = 16'(1 + $urandom % 4);
    end
    configure(1'b1, TRANS_SYNC_IDX, 8'd0, cyc, fd, {16'd0, REP_INFINITE});
    rd = '0;
    while (!rd[1]) begin
      read_reg(ADDR_STATUS, rd);
    end
    repeat (4) @(negedge CLK);
    expected = {20'd0, 4'(cyc[1] - 16'd1), 6'd0, 1'b1, 1'b1};
    read_reg(ADDR_STATUS, rd);
    expect_equal("stop_status", expected, rd);
    exp_seg = 1'b1;
    park_idx = 4'(cyc[1] - 16'd1);
    park_check = 1'b1;
    period = int'(cyc[1]) * int'(fd[1]);
    for (int u = 0; u < STOP_UPDATES; u++) begin
      pulse_update(12 + period + int'($urandom % period));
      read_reg(ADDR_STATUS, rd);
      expect_equal("stop_hold", expected, rd);
    end
  endtask

  always @(posedge CLK) begin
    prev_trans <= intensity[TRANS_W-1:0];
    if (dout_valid && intensity[2:0] == 3'd0) begin
      burst_idx <= intensity[6:3]; // index of the burst now streaming.
    end
  end

  a_phase_inverse: assert property (@(posedge CLK) disable iff (reset)
      dout_valid |-> phase == ~intensity)
    else abort_run($sformatf("error stream_phase expected 0x%0h actual 0x%0h",
                             ~$sampled(intensity), $sampled(phase)));

  a_first_trans: assert property (@(posedge CLK) disable iff (reset)
      $rose(dout_valid) |-> intensity[2:0] == 3'd0)
    else abort_run($sformatf("error stream_first expected 0x0 actual 0x%0h",
                             $sampled(intensity[2:0])));

  a_trans_step: assert property (@(posedge CLK) disable iff (reset)
      dout_valid && $past(dout_valid) |-> intensity[2:0] == prev_trans + 3'd1)
    else abort_run($sformatf("error stream_trans expected 0x%0h actual 0x%0h",
                             3'($sampled(prev_trans) + 3'd1), $sampled(intensity[2:0])));

  a_burst_len: assert property (@(posedge CLK) disable iff (reset)
      $rose(dout_valid) |-> dout_valid [*NUM_TRANS] ##1 !dout_valid)
    else abort_run($sformatf("a burst did not last exactly %0d beats", NUM_TRANS));

  a_start_delay: assert property (@(posedge CLK) disable iff (reset)
      update |-> ##3 $rose(dout_valid))
    else abort_run("a burst did not start 3 cycles after the update strobe");

  a_no_stray: assert property (@(posedge CLK) disable iff (reset)
      $rose(dout_valid) |-> $past(update, 3))
    else abort_run("a burst started without an update strobe 3 cycles before");

  a_idx_range: assert property (@(posedge CLK) disable iff (reset)
      dout_valid |-> 16'(intensity[6:3]) < cyc_q[intensity[7]])
    else abort_run($sformatf("error index_range expected below 0x%0h actual 0x%0h",
                             $sampled(cyc_q[intensity[7]]), $sampled(intensity[6:3])));

  a_segment: assert property (@(posedge CLK) disable iff (reset)
      dout_valid |-> intensity[7] == exp_seg)
    else abort_run($sformatf("error segment expected 0x%0h actual 0x%0h",
                             $sampled(exp_seg), $sampled(intensity[7])));

  a_parked: assert property (@(posedge CLK) disable iff (reset)
      dout_valid && park_check |-> intensity[6:3] == park_idx)
    else abort_run($sformatf("error stop_index expected 0x%0h actual 0x%0h",
                             $sampled(park_idx), $sampled(intensity[6:3])));

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge CLK);
    abort_run($sformatf("the run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  initial begin
    void'($urandom(SEED));
    reset = 1'b1;
    update = 1'b0;
    gpio_in = '0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    cyc_q = {16'd16, 16'd16};
    exp_seg = 1'b0;
    park_check = 1'b0;
    park_idx = '0;
    repeat (8) @(negedge CLK);
    reset = 1'b0;
    fill_memory();
    check_readback();
    for (int r = 0; r < ROUNDS; r++) begin
      run_round(r[0]); // alternate the active segment between rounds.
    end
    check_transitions();
    check_stop();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: compile.f
hdl/stm_pkg.sv
hdl/stm_regs.sv
hdl/stm_timer.sv
hdl/stm_swapchain.sv
hdl/stm_gain.sv
hdl/stm.sv
hdl/stm_top.sv
tb/stm_tb.sv

// File: Bender.yml
package:
  name: stm

sources:
  - hdl/stm_pkg.sv
  - hdl/stm_regs.sv
  - hdl/stm_timer.sv
  - hdl/stm_swapchain.sv
  - hdl/stm_gain.sv
  - hdl/stm.sv
  - hdl/stm_top.sv
  - target: test
    files:
      - tb/stm_tb.sv
